// File: Makefile
VERILATOR   ?= verilator
TOP         ?= tb_load_unit
FILELIST    ?= tb.f
BUILD_DIR   ?= obj_dir
ERROR_LIMIT ?= 100
VFLAGS      ?= --timing --assert
SIM_ARGS    ?= +verilator+error+limit+$(ERROR_LIMIT)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# the simulator exit status is the pass or fail result
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// File: hw/ldbuf_if.sv
// write side of the outstanding-load buffer
interface ldbuf_wr_if
  import load_pkg::*;
#(
  parameter int unsigned NR_LDBUF = 4
);
  localparam int unsigned ID_W = $clog2(NR_LDBUF);

  // load granted this cycle, store it in slot free_id
  logic            w;
  trans_id_t       w_trans_id;
  ld_op_t          w_op;
  byte_off_t       w_off;
  // slot status back toward the controller
  logic            full;
  logic [ID_W-1:0] free_id;

  modport ctrl   (output w, w_trans_id, w_op, w_off, input full, free_id);
  modport buffer (input w, w_trans_id, w_op, w_off, output full, free_id);
endinterface

// read side, the slot addressed by the cache response id
interface ldbuf_rd_if
  import load_pkg::*;
;
  trans_id_t r_trans_id;
  ld_op_t    r_op;
  byte_off_t r_off;
  // slot holds a load that was not flushed
  logic      r_live;

  modport buffer (output r_trans_id, r_op, r_off, r_live);
  modport align  (input r_trans_id, r_op, r_off, r_live);
endinterface

// File: hw/load_align.sv
module load_align
  import load_pkg::*;
(
  // cache response data
  input  logic       data_rvalid_i,
  input  xlen_t      data_rdata_i,
  ldbuf_rd_if.align  rd,
  // result toward the issue stage
  output logic       valid_o,
  output trans_id_t  trans_id_o,
  output xlen_t      result_o
);

  xlen_t             shifted;
  logic [XLEN/8-1:0] sign_bits;
  byte_off_t         sign_idx;
  logic              is_signed;
  logic              sign_bit;

  // only loads that survived a flush retire
  assign valid_o    = data_rvalid_i && rd.r_live;
  assign trans_id_o = rd.r_trans_id;

  // ------------------------------------------------------------------
  // realign and extend
  // ------------------------------------------------------------------
  // bring the loaded field down to bit 0
  assign shifted = data_rdata_i >> {rd.r_off, 3'b000};

  // msb of every byte of the raw word
  for (genvar i = 0; i < XLEN / 8; i++) begin : gen_sign_bits
    assign sign_bits[i] = data_rdata_i[8*i+7];
  end

  // top byte of the field, picked beside the shifter
  always_comb begin
    unique case (rd.r_op)
      LD_W, LD_WU: sign_idx = rd.r_off + byte_off_t'(3);
      LD_H, LD_HU: sign_idx = rd.r_off + byte_off_t'(1);
      default:     sign_idx = rd.r_off;
    endcase
  end

  assign is_signed = rd.r_op inside {LD_B, LD_H, LD_W};
  // unsigned loads pull the fill bit to zero
  assign sign_bit  = is_signed && sign_bits[sign_idx];

  always_comb begin
    unique case (rd.r_op)
      LD_W, LD_WU: result_o = {{(XLEN - 32){sign_bit}}, shifted[31:0]};
      LD_H, LD_HU: result_o = {{(XLEN - 16){sign_bit}}, shifted[15:0]};
      LD_B, LD_BU: result_o = {{(XLEN - 8){sign_bit}}, shifted[7:0]};
      // double passes the whole word
      default:     result_o = shifted;
    endcase
  end

endmodule

// File: hw/load_buffer.sv
module load_buffer
  import load_pkg::*;
#(
  parameter int unsigned NR_LDBUF = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        flush_i,
  // cache response, frees the slot it names
  input  logic                        data_rvalid_i,
  input  logic [$clog2(NR_LDBUF)-1:0] data_rid_i,
  ldbuf_wr_if.buffer                  wr,
  ldbuf_rd_if.buffer                  rd
);

  localparam int unsigned ID_W = $clog2(NR_LDBUF);

  // per slot payload
  trans_id_t          trans_id_q [NR_LDBUF];
  ld_op_t             op_q       [NR_LDBUF];
  byte_off_t          off_q      [NR_LDBUF];
  // per slot control flags
  logic [NR_LDBUF-1:0] valid_d, valid_q;
  logic [NR_LDBUF-1:0] flushed_d, flushed_q;
  logic [ID_W-1:0]     free_id;

  // ------------------------------------------------------------------
  // free slot search
  // ------------------------------------------------------------------
  // scan downward so the lowest free index wins
  always_comb begin
    free_id = '0;
    for (int i = NR_LDBUF - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        free_id = ID_W'(i);
      end
    end
  end

  assign wr.free_id = free_id;
  assign wr.full    = &valid_q;

  // ------------------------------------------------------------------
  // slot flags
  // ------------------------------------------------------------------
  always_comb begin
    valid_d   = valid_q;
    flushed_d = flushed_q;
    // late responses of flushed loads get dropped
    if (flush_i) begin
      flushed_d = '1;
    end
    // a response frees its slot, flushed or not
    if (data_rvalid_i) begin
      valid_d[data_rid_i] = 1'b0;
    end
    // new load takes a free slot, never the one being freed
    if (wr.w) begin
      valid_d[free_id]   = 1'b1;
      flushed_d[free_id] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= '0;
      flushed_q <= '0;
    end else begin
      valid_q   <= valid_d;
      flushed_q <= flushed_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr.w) begin
      trans_id_q[free_id] <= wr.w_trans_id;
      op_q[free_id]       <= wr.w_op;
      off_q[free_id]      <= wr.w_off;
    end
  end

  // combinational read by response id
  assign rd.r_trans_id = trans_id_q[data_rid_i];
  assign rd.r_op       = op_q[data_rid_i];
  assign rd.r_off      = off_q[data_rid_i];
  assign rd.r_live     = valid_q[data_rid_i] && !flushed_q[data_rid_i];

endmodule

// File: hw/load_ctrl.sv
module load_ctrl
  import load_pkg::*;
#(
  parameter int unsigned NR_LDBUF = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        flush_i,
  // load queue head
  input  logic                        valid_i,
  input  trans_id_t                   trans_id_i,
  input  ld_op_t                      op_i,
  input  addr_t                       addr_i,
  output logic                        pop_o,
  // store unit hazard check
  output page_off_t                   page_offset_o,
  input  logic                        page_offset_matches_i,
  // data cache request
  output logic                        data_req_o,
  output addr_t                       data_addr_o,
  output ld_size_t                    data_size_o,
  output logic [$clog2(NR_LDBUF)-1:0] data_id_o,
  input  logic                        data_gnt_i,
  ldbuf_wr_if.ctrl                    wr
);

  ld_state_e state_d, state_q;
  logic      accept;

  // store unit compares only the offset inside the page
  assign page_offset_o = addr_i[PAGE_OFF_W-1:0];
  // the cache takes the full physical address with the request
  assign data_addr_o   = addr_i;
  // op bits 1:0 already encode log2 of the byte count
  assign data_size_o   = ld_size_t'(op_i[1:0]);
  // request id is the buffer slot the load will occupy
  assign data_id_o     = wr.free_id;

  // buffer write fields come straight from the queue head
  assign wr.w_trans_id = trans_id_i;
  assign wr.w_op       = op_i;
  assign wr.w_off      = addr_i[ALIGN_BITS-1:0];

  // no new load while every slot is in flight
  assign accept = valid_i && !wr.full;

  // ------------------------------------------------------------------
  // load control
  // ------------------------------------------------------------------
  always_comb begin
    state_d    = state_q;
    data_req_o = 1'b0;
    pop_o      = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (accept) begin
          if (page_offset_matches_i) begin
            // pending store to the same offset, stall first
            state_d = WAIT_PAGE_OFFSET;
          end else begin
            data_req_o = 1'b1;
            // granted at once, stay here for back to back loads
            if (data_gnt_i) begin
              pop_o = 1'b1;
            end else begin
              state_d = WAIT_GNT;
            end
          end
        end
      end
      WAIT_PAGE_OFFSET: begin
        if (!page_offset_matches_i) begin
          state_d = WAIT_GNT;
        end
      end
      WAIT_GNT: begin
        // request must stay up until the cache grants it
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          pop_o   = 1'b1;
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
    // flush drops whatever is in progress
    if (flush_i) begin
      data_req_o = 1'b0;
      pop_o      = 1'b0;
      state_d    = IDLE;
    end
  end

  // one accepted handshake allocates one slot
  assign wr.w = data_req_o && data_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: hw/load_pkg.sv
package load_pkg;

  // ------------------------------------------------------------------
  // widths
  // ------------------------------------------------------------------
  // data path width of the core
  localparam int unsigned XLEN       = 64;
  // byte offset bits inside one data word
  localparam int unsigned ALIGN_BITS = 3;
  // physical address width toward the data cache
  localparam int unsigned ADDR_W     = 32;
  // scoreboard id width
  localparam int unsigned TRANS_ID_W = 3;
  // page offset compared by the store unit
  localparam int unsigned PAGE_OFF_W = 12;

  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [TRANS_ID_W-1:0] trans_id_t;
  typedef logic [PAGE_OFF_W-1:0] page_off_t;
  typedef logic [ALIGN_BITS-1:0] byte_off_t;

  // ------------------------------------------------------------------
  // load operations
  // ------------------------------------------------------------------
  typedef logic [2:0] ld_op_t;

  // bit 2 set marks the zero extending variants
  localparam ld_op_t LD_B  = 3'b000;
  localparam ld_op_t LD_H  = 3'b001;
  localparam ld_op_t LD_W  = 3'b010;
  localparam ld_op_t LD_D  = 3'b011;
  localparam ld_op_t LD_BU = 3'b100;
  localparam ld_op_t LD_HU = 3'b101;
  localparam ld_op_t LD_WU = 3'b110;

  // log2 of the number of bytes moved
  typedef logic [1:0] ld_size_t;

  // load control FSM
  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    WAIT_PAGE_OFFSET
  } ld_state_e;

endpackage

// File: hw/load_unit.sv
module load_unit
  import load_pkg::*;
#(
  parameter int unsigned NR_LDBUF = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        flush_i,
  // load queue
  input  logic                        valid_i,
  input  trans_id_t                   trans_id_i,
  input  ld_op_t                      op_i,
  input  addr_t                       addr_i,
  output logic                        pop_o,
  // store unit
  output page_off_t                   page_offset_o,
  input  logic                        page_offset_matches_i,
  // data cache request
  output logic                        data_req_o,
  output addr_t                       data_addr_o,
  output ld_size_t                    data_size_o,
  output logic [$clog2(NR_LDBUF)-1:0] data_id_o,
  input  logic                        data_gnt_i,
  // data cache response
  input  logic                        data_rvalid_i,
  input  logic [$clog2(NR_LDBUF)-1:0] data_rid_i,
  input  xlen_t                       data_rdata_i,
  // load result
  output logic                        valid_o,
  output trans_id_t                   trans_id_o,
  output xlen_t                       result_o
);

  // controller to buffer, and buffer to result stage
  ldbuf_wr_if #(.NR_LDBUF(NR_LDBUF)) wr_if ();
  ldbuf_rd_if                        rd_if ();

  // ------------------------------------------------------------------
  // request side
  // ------------------------------------------------------------------
  load_ctrl #(.NR_LDBUF(NR_LDBUF)) u_ctrl (
    .clk_i, .rst_ni, .flush_i,
    .valid_i, .trans_id_i, .op_i, .addr_i, .pop_o,
    .page_offset_o, .page_offset_matches_i,
    .data_req_o, .data_addr_o, .data_size_o, .data_id_o, .data_gnt_i,
    .wr (wr_if.ctrl)
  );

  // outstanding loads, answered in any order
  load_buffer #(.NR_LDBUF(NR_LDBUF)) u_buffer (
    .clk_i, .rst_ni, .flush_i,
    .data_rvalid_i, .data_rid_i,
    .wr (wr_if.buffer),
    .rd (rd_if.buffer)
  );

  // ------------------------------------------------------------------
  // response side
  // ------------------------------------------------------------------
  load_align u_align (
    .data_rvalid_i, .data_rdata_i,
    .rd (rd_if.align),
    .valid_o, .trans_id_o, .result_o
  );

endmodule

// File: tb.f
hw/load_pkg.sv
hw/ldbuf_if.sv
hw/load_ctrl.sv
hw/load_buffer.sv
hw/load_align.sv
hw/load_unit.sv
verification/load_unit_asserts.sv
verification/tb_load_unit.sv

// File: verification/load_unit_asserts.sv
module load_unit_asserts #(
  parameter int unsigned NR_LDBUF = 4
) (
  input logic                        clk_i,
  input logic                        rst_ni,
  input logic                        flush_i,
  input logic                        data_req_o,
  input logic                        data_gnt_i,
  input logic                        pop_o,
  input logic                        data_rvalid_i,
  input logic [$clog2(NR_LDBUF)-1:0] data_id_o,
  input logic [$clog2(NR_LDBUF)-1:0] data_rid_i
);

  // slots granted and not yet answered, seen from the cache side
  logic [NR_LDBUF-1:0] in_flight_q;
  // raised once an assertion has failed
  logic req_hold_fired = 1'b0;
  logic pop_fired      = 1'b0;
  logic id_fired       = 1'b0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_flight_q <= '0;
    end else begin
      if (data_rvalid_i) begin
        in_flight_q[data_rid_i] <= 1'b0;
      end
      if (data_req_o && data_gnt_i) begin
        in_flight_q[data_id_o] <= 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------
  // cache handshake
  // ------------------------------------------------------------------
  // request stays up until granted, only a flush may drop it
  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o && !data_gnt_i |=> data_req_o || flush_i)
    else begin
      $error("cache request dropped before its grant");
      req_hold_fired = 1'b1;
    end

  pop_with_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_o |-> data_req_o && data_gnt_i)
    else begin
      $error("queue popped without a granted request");
      pop_fired = 1'b1;
    end

  // request id must not name a slot still waiting for data
  id_not_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o |-> !in_flight_q[data_id_o])
    else begin
      $error("request id names a slot already in flight");
      id_fired = 1'b1;
    end

endmodule

bind load_unit load_unit_asserts #(.NR_LDBUF(NR_LDBUF)) u_asserts (
  .clk_i(clk_i),
  .rst_ni(rst_ni),
  .flush_i(flush_i),
  .data_req_o(data_req_o),
  .data_gnt_i(data_gnt_i),
  .pop_o(pop_o),
  .data_rvalid_i(data_rvalid_i),
  .data_id_o(data_id_o),
  .data_rid_i(data_rid_i)
);

// File: verification/tb_load_unit.sv
module tb_load_unit
  import load_pkg::*;
;

  localparam int unsigned NR_LDBUF   = 4;
  localparam int unsigned ID_W       = $clog2(NR_LDBUF);
  localparam int unsigned NUM_LOADS  = 400;
  localparam int unsigned MAX_CYCLES = NUM_LOADS * 12;

  // DUT ports, all inputs idle from time zero
  logic            clk_i = 1'b0;
  logic            rst_ni = 1'b0;
  logic            flush_i = 1'b0;
  logic            valid_i = 1'b0;
  trans_id_t       trans_id_i = '0;
  ld_op_t          op_i = LD_B;
  addr_t           addr_i = '0;
  logic            page_offset_matches_i = 1'b0;
  logic            data_gnt_i = 1'b0;
  logic            data_rvalid_i = 1'b0;
  logic [ID_W-1:0] data_rid_i = '0;
  xlen_t           data_rdata_i = '0;
  logic            pop_o, data_req_o, valid_o;
  page_off_t       page_offset_o;
  addr_t           data_addr_o;
  ld_size_t        data_size_o;
  logic [ID_W-1:0] data_id_o;
  trans_id_t       trans_id_o;
  xlen_t           result_o;

  // reference model state, updated on the falling edge
  logic [NR_LDBUF-1:0] busy;
  logic [NR_LDBUF-1:0] dropped;
  trans_id_t           slot_trans [NR_LDBUF];
  ld_op_t              slot_op    [NR_LDBUF];
  byte_off_t           slot_off   [NR_LDBUF];
  ld_state_e           exp_state;
  int unsigned         accepted;
  logic                pop_seen;
  // stimulus side state
  logic [31:0]         lfsr_q = 32'h9241_128d;
  int unsigned         match_left = 0;
  int unsigned         cycles = 0;

  load_unit #(.NR_LDBUF(NR_LDBUF)) uut (.*);

  always #20 clk_i = ~clk_i;

  // ------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------
  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Verification failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic value_mismatch(input string test, input logic [63:0] expected,
                                input logic [63:0] actual);
    stop_on_error($sformatf("error: %s expected 0x%0h actual 0x%0h", test, expected, actual));
  endtask

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [63:0] rand_bits(input int unsigned n);
    logic [63:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v      = {v[62:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // log2 of the bytes a load moves
  function automatic ld_size_t load_size(input ld_op_t op);
    case (op)
      LD_H, LD_HU: return 2'd1;
      LD_W, LD_WU: return 2'd2;
      LD_D:        return 2'd3;
      default:     return 2'd0;
    endcase
  endfunction

  function automatic logic [ID_W-1:0] lowest_free(input logic [NR_LDBUF-1:0] slots);
    for (int unsigned i = 0; i < NR_LDBUF; i++) begin
      if (!slots[i]) begin
        return ID_W'(i);
      end
    end
    return '0;
  endfunction

  // field at the byte offset, then extended by signedness of the op
  function automatic xlen_t expected_result(input xlen_t data, input ld_op_t op,
                                            input byte_off_t off);
    xlen_t field;
    field = data >> (8 * off);
    case (op)
      LD_B:    return xlen_t'($signed(field[7:0]));
      LD_H:    return xlen_t'($signed(field[15:0]));
      LD_W:    return xlen_t'($signed(field[31:0]));
      LD_BU:   return xlen_t'(field[7:0]);
      LD_HU:   return xlen_t'(field[15:0]);
      LD_WU:   return xlen_t'(field[31:0]);
      default: return field;
    endcase
  endfunction

  // ------------------------------------------------------------------
  // stimulus: queue head, store unit and cache responder
  // ------------------------------------------------------------------
  always @(posedge clk_i) begin : drive
    logic        flush_now;
    ld_op_t      op;
    addr_t       addr;
    int unsigned slot;
    if (rst_ni) begin
      flush_now = (rand_bits(6) == 64'd0);
      flush_i <= flush_now;
      // queue is flushed too, so no head during or right after a flush
      if (flush_now) begin
        valid_i <= 1'b0;
      end else if (!valid_i || pop_seen) begin
        if (!flush_i && accepted < NUM_LOADS && rand_bits(2) != 64'd0) begin
          op = ld_op_t'(rand_bits(3));
          if (op == 3'b111) begin
            op = LD_D;
          end
          // naturally aligned address
          addr = addr_t'(rand_bits(32));
          addr = addr & ~((addr_t'(1) << load_size(op)) - addr_t'(1));
          valid_i    <= 1'b1;
          trans_id_i <= trans_id_t'(rand_bits(TRANS_ID_W));
          op_i       <= op;
          addr_i     <= addr;
        end else begin
          valid_i <= 1'b0;
        end
      end
      // store hazard held for one to four cycles
      if (match_left != 0) begin
        match_left = match_left - 1;
      end else if (rand_bits(3) == 64'd0) begin
        match_left = 32'd1 + 32'(rand_bits(2));
      end
      page_offset_matches_i <= (match_left != 0);
      data_gnt_i <= (rand_bits(2) != 64'd0);
      // answer some outstanding slot, any order
      if (busy != '0 && rand_bits(1) == 64'd1) begin
        slot = 32'(rand_bits(ID_W));
        while (!busy[slot]) begin
          slot = (slot + 1) % NR_LDBUF;
        end
        data_rvalid_i <= 1'b1;
        data_rid_i    <= ID_W'(slot);
        data_rdata_i  <= rand_bits(64);
      end else begin
        data_rvalid_i <= 1'b0;
      end
    end
  end

  // ------------------------------------------------------------------
  // checks against the model, mid cycle when everything is settled
  // ------------------------------------------------------------------
  always @(negedge clk_i) begin : check
    ld_state_e next_state;
    logic      exp_req;
    logic      exp_valid;
    if (!rst_ni) begin
      assert (!pop_o && !data_req_o && !valid_o)
        else stop_on_error("pop, request or result active during reset");
      busy      = '0;
      dropped   = '0;
      accepted  = 0;
      pop_seen  = 1'b0;
      exp_state = IDLE;
    end else begin
      assert (!(uut.u_asserts.req_hold_fired || uut.u_asserts.pop_fired ||
                uut.u_asserts.id_fired))
        else stop_on_error("a bound assertion on the cache handshake fired");
      // expected request per the acceptance rules
      next_state = exp_state;
      exp_req    = 1'b0;
      case (exp_state)
        IDLE: begin
          if (valid_i && !(&busy)) begin
            if (page_offset_matches_i) begin
              next_state = WAIT_PAGE_OFFSET;
            end else begin
              exp_req = 1'b1;
              if (!data_gnt_i) begin
                next_state = WAIT_GNT;
              end
            end
          end
        end
        WAIT_PAGE_OFFSET: begin
          if (!page_offset_matches_i) begin
            next_state = WAIT_GNT;
          end
        end
        default: begin
          exp_req = 1'b1;
          if (data_gnt_i) begin
            next_state = IDLE;
          end
        end
      endcase
      if (flush_i) begin
        exp_req    = 1'b0;
        next_state = IDLE;
      end
      assert (data_req_o == exp_req)
        else value_mismatch("request", 64'(exp_req), 64'(data_req_o));
      assert (pop_o == (exp_req && data_gnt_i))
        else value_mismatch("pop", 64'(exp_req && data_gnt_i), 64'(pop_o));
      assert (page_offset_o == addr_i[PAGE_OFF_W-1:0])
        else value_mismatch("page_offset", 64'(addr_i[PAGE_OFF_W-1:0]), 64'(page_offset_o));
      if (data_req_o) begin
        assert (data_id_o == lowest_free(busy))
          else value_mismatch("request_id", 64'(lowest_free(busy)), 64'(data_id_o));
        assert (data_addr_o == addr_i)
          else value_mismatch("address", 64'(addr_i), 64'(data_addr_o));
        assert (data_size_o == load_size(op_i))
          else value_mismatch("size", 64'(load_size(op_i)), 64'(data_size_o));
      end
      // response, flushed loads must stay silent
      if (data_rvalid_i) begin
        exp_valid = !dropped[data_rid_i];
        assert (valid_o == exp_valid)
          else value_mismatch("result_valid", 64'(exp_valid), 64'(valid_o));
        if (exp_valid) begin
          assert (trans_id_o == slot_trans[data_rid_i])
            else value_mismatch("trans_id", 64'(slot_trans[data_rid_i]), 64'(trans_id_o));
          assert (result_o == expected_result(data_rdata_i, slot_op[data_rid_i],
                                              slot_off[data_rid_i]))
            else value_mismatch("result", expected_result(data_rdata_i,
                                slot_op[data_rid_i], slot_off[data_rid_i]), result_o);
        end
        busy[data_rid_i] = 1'b0;
      end else begin
        assert (!valid_o)
          else value_mismatch("result_valid", 64'd0, 64'(valid_o));
      end
      // granted load enters its slot
      if (pop_o) begin
        busy[data_id_o]       = 1'b1;
        dropped[data_id_o]    = 1'b0;
        slot_trans[data_id_o] = trans_id_i;
        slot_op[data_id_o]    = op_i;
        slot_off[data_id_o]   = addr_i[ALIGN_BITS-1:0];
        accepted              = accepted + 1;
      end
      if (flush_i) begin
        dropped = '1;
      end
      pop_seen  = pop_o;
      exp_state = next_state;
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      stop_on_error($sformatf("timeout, loads did not complete within %0d cycles", MAX_CYCLES));
    end
  end

  initial begin : run
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    // all loads accepted and every slot answered
    while (!(accepted >= NUM_LOADS && busy == '0 && !valid_i)) begin
      @(posedge clk_i);
    end
    $display("Verification passed");
    $finish;
  end

endmodule
